// ==== design/rtg_output_mixer.sv ====
`timescale 1ns/1ps
`default_nettype none

module rtg_output_mixer (
  input  logic                              CLK_114,
  input  logic                              rst_n,
  input  logic                              rtg_ena,     // rtg replaces native
  input  logic                              rtg_act,     // inside rtg window
  input  rtg_video_pkg::pixel_word_t        head_word,
  input  logic                              head_valid,
  input  logic [rtg_video_pkg::CHAN_W-1:0]  native_r,
  input  logic [rtg_video_pkg::CHAN_W-1:0]  native_g,
  input  logic [rtg_video_pkg::CHAN_W-1:0]  native_b,
  input  logic                              vs_q,        // vsync from pacer
  input  logic                              hs,
  input  logic                              cs,
  input  logic                              osd_window,
  input  logic                              osd_pixel,
  output logic [rtg_video_pkg::CHAN_W-1:0]  vga_r,
  output logic [rtg_video_pkg::CHAN_W-1:0]  vga_g,
  output logic [rtg_video_pkg::CHAN_W-1:0]  vga_b,
  output logic                              vga_vs,
  output logic                              vga_hs,
  output logic                              vga_cs
);

  localparam int CW = rtg_video_pkg::CHAN_W;
  localparam int OB = rtg_video_pkg::OSD_BITS;

  logic [CW-1:0] rtg_r, rtg_g, rtg_b;   // expanded rtg colour
  logic [CW-1:0] sel_r, sel_g, sel_b;   // after source select
  logic [OB-1:0] osd_rg, osd_b;         // osd top bits

  ////////////////////////////////
  // expand, select, osd colour
  ////////////////////////////////
  always_comb begin
    if (rtg_act && head_valid) begin
      rtg_r = {head_word[15:11], head_word[15:13]};   // 5 -> 8, repeat msbs
      rtg_g = {head_word[10:5], head_word[10:9]};     // 6 -> 8
      rtg_b = {head_word[4:0], head_word[4:2]};
    end else begin
      rtg_r = '0;                                     // black border
      rtg_g = '0;
      rtg_b = '0;
    end
    sel_r  = rtg_ena ? rtg_r : native_r;
    sel_g  = rtg_ena ? rtg_g : native_g;
    sel_b  = rtg_ena ? rtg_b : native_b;
    osd_rg = osd_pixel ? '1 : '0;
    osd_b  = osd_pixel ? '1 : rtg_video_pkg::OSD_BLUE_BG;  // bluish background
  end

  ////////////////////////////////
  // output registers
  ////////////////////////////////
  always_ff @(posedge CLK_114 or negedge rst_n) begin
    if (!rst_n) begin
      vga_r  <= '0;
      vga_g  <= '0;
      vga_b  <= '0;
      vga_vs <= 1'b0;
      vga_hs <= 1'b0;
      vga_cs <= 1'b0;
    end else begin
      // osd shifts the picture down under its own top bits
      vga_r  <= osd_window ? {osd_rg, sel_r[CW-1:OB]} : sel_r;
      vga_g  <= osd_window ? {osd_rg, sel_g[CW-1:OB]} : sel_g;
      vga_b  <= osd_window ? {osd_b, sel_b[CW-1:OB]} : sel_b;
      vga_vs <= vs_q;
      vga_hs <= hs;
      vga_cs <= cs;
    end
  end

endmodule

`default_nettype wire

// ==== design/rtg_pixel_pacer.sv ====
`timescale 1ns/1ps
`default_nettype none

module rtg_pixel_pacer (
  input  logic CLK_114,
  input  logic rst_n,
  input  logic rtg_act,      // rtg window active
  input  logic vs,           // vertical sync from chipset
  output logic pixel_tick,   // one pop per rtg pixel
  output logic frame_start,  // falling vsync edge
  output logic vs_q          // registered vsync
);

  logic [rtg_video_pkg::DIV_W-1:0] div_cnt;   // clocks into current pixel

  ////////////////////////////////
  // pixel divider
  ////////////////////////////////

  // last count of the pixel, gated so a stale count never ticks
  assign pixel_tick = rtg_act && (div_cnt == rtg_video_pkg::DIV_LAST);

  always_ff @(posedge CLK_114 or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= '0;
    end else if (!rtg_act || pixel_tick) begin
      div_cnt <= '0;                 // idle outside window, wrap on tick
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  ////////////////////////////////
  // frame start
  ////////////////////////////////

  always_ff @(posedge CLK_114 or negedge rst_n) begin
    if (!rst_n) begin
      vs_q <= 1'b0;
    end else begin
      vs_q <= vs;                    // one clock of history
    end
  end

  assign frame_start = vs_q && !vs;  // high then low -> new frame

endmodule

`default_nettype wire

// ==== design/rtg_stream_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module rtg_stream_buffer (
  input  logic                              CLK_114,
  input  logic                              rst_n,
  input  logic                              rtg_ena,     // fetch allowed
  input  logic                              pixel_tick,  // pop head
  input  logic                              frame_start, // flush, restart at base
  output logic                              mem_req,     // one-cycle burst request
  output logic [rtg_video_pkg::ADDR_W-1:0]  mem_addr,    // valid with mem_req
  input  logic                              mem_fill,    // one word returned
  input  rtg_video_pkg::pixel_word_t        mem_data,
  output rtg_video_pkg::pixel_word_t        head_word,   // show-ahead head
  output logic                              head_valid,
  output logic                              underrun     // sticky until frame_start
);

  ////////////////////////////////
  // state
  ////////////////////////////////
  rtg_video_pkg::pixel_word_t word_mem [rtg_video_pkg::BUF_DEPTH];  // circular store

  logic [rtg_video_pkg::CNT_W-1:0]  wr_ptr;      // extra msb marks wrap
  logic [rtg_video_pkg::CNT_W-1:0]  rd_ptr;
  logic [rtg_video_pkg::CNT_W-1:0]  count;       // words stored
  logic [rtg_video_pkg::CNT_W-1:0]  owed;        // words still due for this frame
  logic [rtg_video_pkg::CNT_W-1:0]  drop_cnt;    // words due for flushed requests
  logic [rtg_video_pkg::CNT_W-1:0]  req_words;   // burst now on the port
  logic [rtg_video_pkg::CNT_W:0]    pending;     // stored + every word still coming
  logic [rtg_video_pkg::ADDR_W-1:0] fetch_addr;  // next burst address

  logic empty;
  logic pop;
  logic fill_drop;
  logic fill_keep;
  logic issue;

  ////////////////////////////////
  // fetch decision
  ////////////////////////////////
  always_comb begin
    count     = wr_ptr - rd_ptr;
    empty     = (count == '0);
    pop       = pixel_tick && !empty;
    fill_drop = mem_fill && (drop_cnt != '0);   // stale words arrive first
    fill_keep = mem_fill && (drop_cnt == '0);
    req_words = mem_req ? rtg_video_pkg::BURST_CNT : '0;
    pending   = {1'b0, count} + {1'b0, owed} + {1'b0, drop_cnt};
    // room for a whole burst, one request at a time
    issue     = rtg_ena && !mem_req && !frame_start
                && (pending <= rtg_video_pkg::FETCH_LIMIT);
  end

  assign head_word  = word_mem[rd_ptr[rtg_video_pkg::PTR_W-1:0]];
  assign head_valid = !empty;

  ////////////////////////////////
  // control
  ////////////////////////////////
  always_ff @(posedge CLK_114 or negedge rst_n) begin
    if (!rst_n) begin
      mem_req    <= 1'b0;
      fetch_addr <= rtg_video_pkg::BASE_ADDR;
      owed       <= '0;
      drop_cnt   <= '0;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      underrun   <= 1'b0;
    end else if (frame_start) begin
      mem_req    <= 1'b0;
      fetch_addr <= rtg_video_pkg::BASE_ADDR;
      owed       <= '0;
      // everything still coming is now stale, incl. a burst on the port
      drop_cnt   <= drop_cnt + owed + req_words - {{(rtg_video_pkg::CNT_W - 1){1'b0}}, mem_fill};
      wr_ptr     <= '0;                     // empty buffer
      rd_ptr     <= '0;
      underrun   <= 1'b0;
    end else begin
      mem_req <= issue;
      if (issue) begin
        fetch_addr <= fetch_addr + rtg_video_pkg::ADDR_STEP;
      end
      // burst counted once it has left on the port
      owed     <= owed + req_words - {{(rtg_video_pkg::CNT_W - 1){1'b0}}, fill_keep};
      drop_cnt <= drop_cnt - {{(rtg_video_pkg::CNT_W - 1){1'b0}}, fill_drop};
      if (fill_keep) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (pixel_tick && empty) begin
        underrun <= 1'b1;                   // pixel due, nothing stored
      end
    end
  end

  ////////////////////////////////
  // payload
  ////////////////////////////////
  always_ff @(posedge CLK_114) begin
    if (issue) begin
      mem_addr <= fetch_addr;               // held for the request cycle
    end
    if (fill_keep && !frame_start) begin
      word_mem[wr_ptr[rtg_video_pkg::PTR_W-1:0]] <= mem_data;
    end
  end

endmodule

`default_nettype wire

// ==== design/rtg_video_pkg.sv ====
`default_nettype none

package rtg_video_pkg;

  ////////////////////////////////
  // widths
  ////////////////////////////////
  localparam int RGB565_W  = 16;          // one stored rtg pixel
  localparam int CHAN_W    = 8;           // one vga colour channel
  localparam int ADDR_W    = 22;          // word address on memory port

  ////////////////////////////////
  // stream constants
  ////////////////////////////////
  localparam logic [ADDR_W-1:0] BASE_ADDR = '0;   // frame start address
  localparam int PIXEL_DIV = 3;           // clocks per rtg pixel
  localparam int BURST_LEN = 4;           // words per request
  localparam int BUF_DEPTH = 16;          // words in stream buffer
  localparam int OSD_BITS  = 2;           // top bits taken by osd

  // derived values
  localparam int DIV_W = $clog2(PIXEL_DIV);        // divider counter width
  localparam int PTR_W = $clog2(BUF_DEPTH);        // buffer index width
  localparam int CNT_W = PTR_W + 1;                // ptr with wrap bit, word counts
  localparam logic [DIV_W-1:0]  DIV_LAST    = DIV_W'(PIXEL_DIV - 1);
  localparam logic [CNT_W-1:0]  BURST_CNT   = CNT_W'(BURST_LEN);
  localparam logic [CNT_W:0]    FETCH_LIMIT = (CNT_W + 1)'(BUF_DEPTH - BURST_LEN);
  localparam logic [ADDR_W-1:0] ADDR_STEP   = ADDR_W'(BURST_LEN);
  localparam logic [OSD_BITS-1:0] OSD_BLUE_BG = {1'b1, {(OSD_BITS - 1){1'b0}}}; // 10 on blue

  typedef logic [RGB565_W-1:0] pixel_word_t;   // r5 g6 b5

endpackage

`default_nettype wire

// ==== design/rtg_video_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rtg_video_top (
  input  logic                              CLK_114,
  input  logic                              rst_n,
  // chipset side
  input  logic                              rtg_ena,
  input  logic                              rtg_act,
  input  logic [rtg_video_pkg::CHAN_W-1:0]  native_r,
  input  logic [rtg_video_pkg::CHAN_W-1:0]  native_g,
  input  logic [rtg_video_pkg::CHAN_W-1:0]  native_b,
  input  logic                              vs,
  input  logic                              hs,
  input  logic                              cs,
  input  logic                              osd_window,
  input  logic                              osd_pixel,
  // memory port
  output logic                              mem_req,
  output logic [rtg_video_pkg::ADDR_W-1:0]  mem_addr,
  input  logic                              mem_fill,
  input  rtg_video_pkg::pixel_word_t        mem_data,
  // vga
  output logic [rtg_video_pkg::CHAN_W-1:0]  vga_r,
  output logic [rtg_video_pkg::CHAN_W-1:0]  vga_g,
  output logic [rtg_video_pkg::CHAN_W-1:0]  vga_b,
  output logic                              vga_vs,
  output logic                              vga_hs,
  output logic                              vga_cs,
  output logic                              underrun
);

  logic                       pixel_tick;   // pacer -> buffer
  logic                       frame_start;
  logic                       vs_q;         // pacer -> mixer
  rtg_video_pkg::pixel_word_t head_word;    // buffer -> mixer
  logic                       head_valid;

  rtg_pixel_pacer pacer_i (
    .CLK_114     (CLK_114),
    .rst_n       (rst_n),
    .rtg_act     (rtg_act),
    .vs          (vs),
    .pixel_tick  (pixel_tick),
    .frame_start (frame_start),
    .vs_q        (vs_q)
  );

  rtg_stream_buffer buffer_i (
    .CLK_114     (CLK_114),
    .rst_n       (rst_n),
    .rtg_ena     (rtg_ena),
    .pixel_tick  (pixel_tick),
    .frame_start (frame_start),
    .mem_req     (mem_req),
    .mem_addr    (mem_addr),
    .mem_fill    (mem_fill),
    .mem_data    (mem_data),
    .head_word   (head_word),
    .head_valid  (head_valid),
    .underrun    (underrun)
  );

  rtg_output_mixer mixer_i (
    .CLK_114     (CLK_114),
    .rst_n       (rst_n),
    .rtg_ena     (rtg_ena),
    .rtg_act     (rtg_act),
    .head_word   (head_word),
    .head_valid  (head_valid),
    .native_r    (native_r),
    .native_g    (native_g),
    .native_b    (native_b),
    .vs_q        (vs_q),
    .hs          (hs),
    .cs          (cs),
    .osd_window  (osd_window),
    .osd_pixel   (osd_pixel),
    .vga_r       (vga_r),
    .vga_g       (vga_g),
    .vga_b       (vga_b),
    .vga_vs      (vga_vs),
    .vga_hs      (vga_hs),
    .vga_cs      (vga_cs)
  );

endmodule

`default_nettype wire

// ==== flist.f ====
design/rtg_video_pkg.sv
design/rtg_pixel_pacer.sv
design/rtg_stream_buffer.sv
design/rtg_output_mixer.sv
design/rtg_video_top.sv
tb/rtg_video_assert.sv
tb/tb_rtg_video.sv

// ==== tb/rtg_video_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module rtg_video_assert (
  input logic                           CLK_114,
  input logic                           rst_n,
  input logic                           mem_req,
  input logic                           pixel_tick,
  input logic                           frame_start,
  input logic                           empty,
  input logic                           underrun,
  input logic [rtg_video_pkg::CNT_W:0]  pending     // stored + owed + stale words
);

  int fail_cnt = 0;   // read by the testbench at the end

  ////////////////////////////////
  // buffer rules
  ////////////////////////////////
  no_overfetch_a : assert property (@(posedge CLK_114) disable iff (!rst_n)
    $rose(mem_req) |-> ($past(pending) <= rtg_video_pkg::FETCH_LIMIT))
    else begin
      fail_cnt++;
      $error("burst requested without room for a whole burst");
    end

  empty_pop_a : assert property (@(posedge CLK_114) disable iff (!rst_n)
    (pixel_tick && empty && !frame_start) |=> underrun)
    else begin
      fail_cnt++;
      $error("pixel due on empty buffer without underrun");
    end

  flush_req_a : assert property (@(posedge CLK_114) disable iff (!rst_n)
    frame_start |=> !mem_req)
    else begin
      fail_cnt++;
      $error("request issued right after frame start");
    end

endmodule

bind rtg_stream_buffer rtg_video_assert assert_i (
  .CLK_114     (CLK_114),
  .rst_n       (rst_n),
  .mem_req     (mem_req),
  .pixel_tick  (pixel_tick),
  .frame_start (frame_start),
  .empty       (empty),
  .underrun    (underrun),
  .pending     (pending)
);

`default_nettype wire

// ==== tb/tb_rtg_video.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rtg_video;

  localparam int IMG_WORDS = 24;    // image words in data file
  localparam int OSD_CASES = 4;     // osd cases after the image
  localparam int MEM_LAT   = 4;     // cycles from request to first fill
  localparam int N_NATIVE  = 40;
  localparam int N_OSD     = 24;
  localparam int PREFILL   = 50;
  localparam int N_STREAM1 = 60;
  localparam int N_STREAM2 = 45;
  localparam int UNDER_MAX = 100;
  localparam int TEST_CYCLES = 10 + N_NATIVE + N_OSD + 3 * (PREFILL + 8)
                               + N_STREAM1 + N_STREAM2 + UNDER_MAX + 20;
  localparam int TIMEOUT = 2 * TEST_CYCLES;

  logic CLK_114, rst_n, rtg_ena, rtg_act, vs, hs, cs, osd_window, osd_pixel;
  logic [7:0] native_r, native_g, native_b, vga_r, vga_g, vga_b;
  logic vga_vs, vga_hs, vga_cs, underrun, mem_req, mem_fill;
  logic [rtg_video_pkg::ADDR_W-1:0] mem_addr;
  rtg_video_pkg::pixel_word_t mem_data;

  logic [15:0] file_words [IMG_WORDS + OSD_CASES];
  logic [rtg_video_pkg::ADDR_W-1:0] word_addr_q [$];   // memory model words in flight
  logic [rtg_video_pkg::ADDR_W-1:0] exp_addr;
  int word_due_q [$];
  int errors, checks, cyc, mem_cyc, req_count, afail;
  logic mem_stop, vs_seen;
  logic [31:0] lcg_state;

  rtg_video_top dut_i (.*);

  always #50 CLK_114 = ~CLK_114;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // image from file with an address pattern above it
  function automatic logic [15:0] image_word(input logic [rtg_video_pkg::ADDR_W-1:0] a);
    if (a < IMG_WORDS) return file_words[a];
    return a[15:0] ^ {10'b0, a[21:16]} ^ 16'h5a5a;
  endfunction

  // osd bits on top of the colour shifted down by two
  function automatic logic [7:0] osd_mix(input logic win, pix, blue, input logic [7:0] v);
    logic [1:0] top;
    top = pix ? 2'b11 : (blue ? 2'b10 : 2'b00);
    return win ? {top, v[7:2]} : v;
  endfunction

  task automatic check_val(input string what, input logic [31:0] got, exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////
  // memory model, address monitor, timeout
  ////////////////////////////////
  always @(posedge CLK_114) begin
    mem_cyc++;
    if (rst_n && mem_req && !mem_stop) begin
      for (int i = 0; i < rtg_video_pkg::BURST_LEN; i++) begin
        word_addr_q.push_back(mem_addr + i);   // one burst in address order
        word_due_q.push_back(mem_cyc + MEM_LAT);
      end
    end
    if (word_due_q.size() > 0 && word_due_q[0] <= mem_cyc) begin
      mem_fill <= 1'b1;
      mem_data <= image_word(word_addr_q.pop_front());
      void'(word_due_q.pop_front());
    end else begin
      mem_fill <= 1'b0;
    end
  end

  always @(posedge CLK_114) begin
    if (rst_n) begin
      if (mem_req) begin
        check_val("mem_addr", mem_addr, exp_addr);
        exp_addr = exp_addr + rtg_video_pkg::BURST_LEN;   // bursts back to back
        req_count++;
      end
      if (vs_seen && !vs) exp_addr = rtg_video_pkg::BASE_ADDR;   // frame start
      vs_seen = vs;
    end
  end

  always @(posedge CLK_114) begin
    cyc++;
    if (cyc >= TIMEOUT) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
      $display("checks=%0d errors=%0d", checks, errors + 1);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  ////////////////////////////////
  // stimulus tasks
  ////////////////////////////////
  task automatic run_native(input int n, input bit with_osd);
    logic [7:0] pr, pg, pb;
    logic phs, pcs, pvs, ppvs, pwin, ppix;
    logic [31:0] rnd;
    pr = native_r;
    pg = native_g;
    pb = native_b;
    phs = hs;
    pcs = cs;
    pvs = vs;
    ppvs = vs;
    pwin = osd_window;
    ppix = osd_pixel;
    for (int i = 0; i < n; i++) begin
      @(posedge CLK_114);
      rnd = lcg_next();
      native_r <= rnd[31:24];
      native_g <= rnd[23:16];
      native_b <= rnd[15:8];
      hs <= rnd[7];
      cs <= rnd[6];
      vs <= rnd[5];
      osd_window <= with_osd;
      osd_pixel <= with_osd & rnd[4];
      if (with_osd && i < OSD_CASES) begin   // fixed cases from file first
        native_r <= file_words[IMG_WORDS + i][7:0];
        native_g <= file_words[IMG_WORDS + i][7:0];
        native_b <= file_words[IMG_WORDS + i][7:0];
        osd_pixel <= file_words[IMG_WORDS + i][8];
      end
      @(negedge CLK_114);
      check_val("vga_r", vga_r, osd_mix(pwin, ppix, 1'b0, pr));
      check_val("vga_g", vga_g, osd_mix(pwin, ppix, 1'b0, pg));
      check_val("vga_b", vga_b, osd_mix(pwin, ppix, 1'b1, pb));
      check_val("vga_hs", vga_hs, phs);
      check_val("vga_cs", vga_cs, pcs);
      check_val("vga_vs", vga_vs, ppvs);   // vsync is registered twice
      pr = native_r;
      pg = native_g;
      pb = native_b;
      phs = hs;
      pcs = cs;
      ppvs = pvs;
      pvs = vs;
      pwin = osd_window;
      ppix = osd_pixel;
    end
    @(posedge CLK_114);
    {vs, hs, cs, osd_window, osd_pixel} <= '0;
    repeat (2) @(posedge CLK_114);
    @(negedge CLK_114);
  endtask

  task automatic vsync_fall();
    @(posedge CLK_114) vs <= 1'b1;
    repeat (2) @(posedge CLK_114);
    vs <= 1'b0;
    @(negedge CLK_114);   // frame start cycle
  endtask

  task automatic run_stream(input int n, input bit with_osd);
    logic pwin, ppix;
    logic [15:0] w;
    logic [31:0] rnd;
    @(posedge CLK_114) rtg_act <= 1'b1;
    pwin = 1'b0;
    ppix = 1'b0;
    for (int k = 1; k <= n; k++) begin
      @(posedge CLK_114);
      rnd = lcg_next();
      osd_window <= with_osd & rnd[31];
      osd_pixel <= rnd[30];
      @(negedge CLK_114);
      // head advances once per pixel period after rtg_act rises
      w = image_word(rtg_video_pkg::BASE_ADDR + (k - 1) / rtg_video_pkg::PIXEL_DIV);
      check_val("vga_r", vga_r, osd_mix(pwin, ppix, 1'b0, {w[15:11], w[15:13]}));
      check_val("vga_g", vga_g, osd_mix(pwin, ppix, 1'b0, {w[10:5], w[10:9]}));
      check_val("vga_b", vga_b, osd_mix(pwin, ppix, 1'b1, {w[4:0], w[4:2]}));
      pwin = osd_window;
      ppix = osd_pixel;
    end
    @(posedge CLK_114);
    {rtg_act, osd_window, osd_pixel} <= '0;
    @(negedge CLK_114);
    check_val("underrun", underrun, 0);
  endtask

  ////////////////////////////////
  // main sequence
  ////////////////////////////////
  initial begin
    int waited;
    int req_before;
    CLK_114 = 1'b0;
    rst_n = 1'b0;
    {rtg_ena, rtg_act, vs, hs, cs, osd_window, osd_pixel, mem_fill} = '0;
    {native_r, native_g, native_b} = '0;
    mem_data = '0;
    {errors, checks, cyc, mem_cyc, req_count} = '0;
    {mem_stop, vs_seen} = '0;
    exp_addr = rtg_video_pkg::BASE_ADDR;
    lcg_state = 32'hbb42;
    $readmemh("tb/video_input.dat", file_words);
    repeat (5) @(posedge CLK_114);
    rst_n <= 1'b1;
    @(negedge CLK_114);
    check_val("mem_req", mem_req, 0);
    check_val("underrun", underrun, 0);
    check_val("outputs", {vga_r, vga_g, vga_b, vga_vs, vga_hs, vga_cs}, 0);

    run_native(N_NATIVE, 1'b0);
    run_native(N_OSD, 1'b1);

    vsync_fall();
    @(posedge CLK_114) rtg_ena <= 1'b1;   // prefill before the window opens
    repeat (PREFILL) @(posedge CLK_114);
    run_stream(N_STREAM1, 1'b0);

    vsync_fall();                          // restart partway through the image
    @(negedge CLK_114);
    req_before = req_count;                // only requests after the flush
    repeat (PREFILL) @(posedge CLK_114);
    assert (req_count > req_before) else begin
      errors++;
      $display("No burst request after the frame restart");
    end
    run_stream(N_STREAM2, 1'b1);

    mem_stop = 1'b1;                       // memory goes silent
    @(posedge CLK_114) rtg_act <= 1'b1;
    waited = 0;
    do begin
      @(negedge CLK_114);
      waited++;
    end while (!underrun && waited < UNDER_MAX);
    assert (underrun && waited >= rtg_video_pkg::PIXEL_DIV * rtg_video_pkg::BURST_LEN)
    else begin
      errors++;
      $display("Underrun did not rise after the buffer ran dry (%0d cycles)", waited);
    end
    @(posedge CLK_114) rtg_act <= 1'b0;
    repeat (2) @(negedge CLK_114);
    check_val("underrun", underrun, 1);   // held with no frame start
    vsync_fall();
    @(negedge CLK_114);
    check_val("underrun", underrun, 0);

    afail = dut_i.buffer_i.assert_i.fail_cnt;
    $display("checks=%0d errors=%0d assertion_failures=%0d", checks, errors, afail);
    if (errors == 0 && afail == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/video_input.dat ====
// words 0..23: rtg memory image, one rgb565 word per word address
// words 24..27: osd cases, bit 8 osd_pixel, bits 7:0 native level on r, g and b
f800
07e0
001f
ffff
0000
8410
f81f
07ff
ffe0
1234
abcd
5a5a
a5a5
0f0f
f0f0
3c3c
c3c3
7bef
8000
0001
4208
bdf7
6b4d
94b2
0100
00ff
01a5
003c
